//--- Bender.yml
package:
  name: tlp_txresp_cntrl

sources:
  - files:
      - hw/tlp_pkg.sv
      - hw/txresp_pkg.sv
      - hw/txresp_seg_if.sv
      - hw/txresp_req_decode.sv
      - hw/txresp_split_fsm.sv
      - hw/txresp_credit_tracker.sv
      - hw/txresp_hdr_build.sv
      - hw/tlp_txresp_cntrl.sv
  - target: test
    files:
      - testbench/tb_clkgen.sv
      - testbench/txresp_checker.sv
      - testbench/tb_txresp.sv

//--- hw/tlp_pkg.sv
`default_nettype none

package tlp_pkg;

  // byte counts cover a full 4 KB read plus one
  localparam int BCNT_W = 13;

  // read completion boundary in bytes
  localparam int RCB_BYTES = 128;

  // pending-read FIFO word, msb first
  typedef struct packed {
    logic        is_uns_rd_size;
    logic [3:0]  lbe;
    logic [2:0]  tc;
    logic [1:0]  attr;
    logic [3:0]  fbe;
    logic [10:0] dwlen;
    logic [15:0] requester_id;
    logic        is_flush;
    logic [4:0]  addr_dw;
    logic [1:0]  rsvd0;
    logic [7:0]  tag;
  } pndg_rd_t;

  // command FIFO completion header, msb first
  typedef struct packed {
    logic [2:0]  rsvd0;
    logic [1:0]  attr;
    logic [8:0]  dw_len;
    logic [2:0]  tc;
    logic [11:0] remain_bytes;
    logic        is_flush;
    logic        cpl_mark;
    logic [35:0] rsvd1;
    logic        is_uns_rd_size;
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [6:0]  lower_addr;
  } cpl_hdr_t;

endpackage

`default_nettype wire

//--- hw/tlp_txresp_cntrl.sv
`timescale 1ns/1ps
`default_nettype none

module tlp_txresp_cntrl #(
  parameter int CPLBUF_ADDR_W = 9,
  parameter int BEAT_BYTES    = 16
) (
  input  wire logic                AvlClk_i,
  input  wire logic                Rstn_i,
  input  wire logic                RxPndgRdFifoEmpty_i,
  input  wire logic [56:0]         RxPndgRdFifoDato_i,
  output logic                     RxPndgRdFifoRdReq_o,
  input  wire logic                TxReadDataValid_i,
  output logic [98:0]              CplReqHeader_o,
  output logic                     CplReqWr_o,
  output logic [CPLBUF_ADDR_W-1:0] CplRamWrAddr_o,
  input  wire logic [3:0]          CmdFifoUsedw_i,
  input  wire logic                CmdFifoBusy_i,
  input  wire logic [31:0]         DevCsr_i,
  output logic                     TxRespIdle_o
);

  tlp_pkg::pndg_rd_t desc;
  tlp_pkg::cpl_hdr_t hdr;
  logic [2:0]        first_mask;
  logic [2:0]        last_mask;
  logic [6:0]        lower_addr;

  txresp_seg_if seg_if ();

  // descriptor is captured on the read strobe of the show-ahead FIFO
  txresp_req_decode u_req_decode (
    .AvlClk_i     (AvlClk_i),
    .Rstn_i       (Rstn_i),
    .load_i       (RxPndgRdFifoRdReq_o),
    .rd_word_i    (RxPndgRdFifoDato_i),
    .desc_o       (desc),
    .first_mask_o (first_mask),
    .last_mask_o  (last_mask),
    .lower_addr_o (lower_addr)
  );

  txresp_split_fsm u_split_fsm (
    .AvlClk_i      (AvlClk_i),
    .Rstn_i        (Rstn_i),
    .fifo_empty_i  (RxPndgRdFifoEmpty_i),
    .dev_csr_mps_i (DevCsr_i[7:5]),
    .cmd_busy_i    (CmdFifoBusy_i),
    .cmd_usedw_i   (CmdFifoUsedw_i),
    .desc_i        (desc),
    .rd_req_o      (RxPndgRdFifoRdReq_o),
    .idle_o        (TxRespIdle_o),
    .seg           (seg_if.splitter)
  );

  txresp_credit_tracker #(
    .CPLBUF_ADDR_W (CPLBUF_ADDR_W),
    .BEAT_BYTES    (BEAT_BYTES)
  ) u_credit_tracker (
    .AvlClk_i      (AvlClk_i),
    .Rstn_i        (Rstn_i),
    .data_valid_i  (TxReadDataValid_i),
    .desc_i        (desc),
    .seg           (seg_if.credit),
    .cplbuf_addr_o (CplRamWrAddr_o)
  );

  txresp_hdr_build u_hdr_build (
    .AvlClk_i     (AvlClk_i),
    .Rstn_i       (Rstn_i),
    .desc_i       (desc),
    .first_mask_i (first_mask),
    .last_mask_i  (last_mask),
    .lower_addr_i (lower_addr),
    .seg          (seg_if.header),
    .hdr_o        (hdr),
    .hdr_wr_o     (CplReqWr_o)
  );

  assign CplReqHeader_o = hdr;

endmodule

`default_nettype wire

//--- hw/txresp_credit_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module txresp_credit_tracker #(
  parameter int CPLBUF_ADDR_W = 9,
  parameter int BEAT_BYTES    = 16
) (
  input  wire logic               AvlClk_i,
  input  wire logic               Rstn_i,
  input  wire logic               data_valid_i,
  input  wire tlp_pkg::pndg_rd_t  desc_i,
  txresp_seg_if.credit            seg,
  output logic [CPLBUF_ADDR_W-1:0] cplbuf_addr_o
);

  localparam int CW = txresp_pkg::CREDIT_W;

  logic [CW-1:0]            limit_q;
  logic [CW-1:0]            consumed_q;
  logic [CW-1:0]            required_q;
  logic [CW-1:0]            avail;
  logic [CW-1:0]            seg_credit;
  logic                     armed_q;
  logic                     payload_ok_q;
  logic                     carries_data;
  logic [CPLBUF_ADDR_W-1:0] addr_q;

  // flush and unsupported-size completions carry no read data
  assign carries_data = !desc_i.is_flush && !desc_i.is_uns_rd_size;
  assign seg_credit   = seg.seg_bytes[CW-1:0];
  assign avail        = limit_q - required_q;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      limit_q      <= '0;
      consumed_q   <= '0;
      required_q   <= '0;
      armed_q      <= 1'b0;
      payload_ok_q <= 1'b0;
      addr_q       <= '0;
    end
    else
    begin
      if (data_valid_i)
      begin
        limit_q <= limit_q + CW'(BEAT_BYTES);
        addr_q  <= addr_q + 1'b1;
      end
      if (seg.send && carries_data)
        consumed_q <= consumed_q + seg_credit;
      if (seg.plan)
        required_q <= consumed_q + seg_credit;
      // only a planned segment can be granted
      if (seg.load || seg.send)
        armed_q <= 1'b0;
      else if (seg.plan)
        armed_q <= 1'b1;
      payload_ok_q <= armed_q && (avail <= CW'(txresp_pkg::CREDIT_WINDOW));
    end
  end

  assign seg.payload_ok = payload_ok_q;
  assign cplbuf_addr_o  = addr_q;

endmodule

`default_nettype wire

//--- hw/txresp_hdr_build.sv
`timescale 1ns/1ps
`default_nettype none

module txresp_hdr_build (
  input  wire logic              AvlClk_i,
  input  wire logic              Rstn_i,
  input  wire tlp_pkg::pndg_rd_t desc_i,
  input  wire logic [2:0]        first_mask_i,
  input  wire logic [2:0]        last_mask_i,
  input  wire logic [6:0]        lower_addr_i,
  txresp_seg_if.header           seg,
  output tlp_pkg::cpl_hdr_t      hdr_o,
  output logic                   hdr_wr_o
);

  logic [tlp_pkg::BCNT_W-1:0] owed_q;
  logic [tlp_pkg::BCNT_W-1:0] masks;
  logic [tlp_pkg::BCNT_W-1:0] remain_d;
  logic [11:0]                remain_q;
  logic [6:0]                 lower_addr_q;
  logic                       first_q;
  logic                       first_sent;
  logic [8:0]                 dw_len;

  assign first_sent = seg.send && (seg.kind == txresp_pkg::CPL_FIRST);

  // first byte enable only trims the first completion
  assign masks = tlp_pkg::BCNT_W'(last_mask_i)
               + (first_q ? tlp_pkg::BCNT_W'(first_mask_i) : '0);

  assign remain_d = desc_i.is_flush ? 13'd1 : (owed_q - masks);

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      first_q <= 1'b0;
    else if (seg.load)
      first_q <= 1'b1;
    else if (first_sent)
      first_q <= 1'b0;
  end

  always_ff @(posedge AvlClk_i)
  begin
    if (seg.load)
      owed_q <= {desc_i.dwlen, 2'b00};
    else if (seg.send)
      owed_q <= owed_q - seg.seg_bytes;
    // a full 4 KB count wraps to zero as the header expects
    remain_q <= remain_d[11:0];
    if (seg.load)
      lower_addr_q <= lower_addr_i;
    else if (first_sent)
      lower_addr_q <= '0;
  end

  always_comb
  begin
    if (desc_i.is_uns_rd_size)
      dw_len = 9'd0;
    else if (desc_i.is_flush)
      dw_len = 9'd1;
    else
      dw_len = seg.seg_bytes[10:2];
  end

  always_comb
  begin
    hdr_o                = '0;
    hdr_o.attr           = desc_i.attr;
    hdr_o.dw_len         = dw_len;
    hdr_o.tc             = desc_i.tc;
    hdr_o.remain_bytes   = remain_q;
    hdr_o.is_flush       = desc_i.is_flush;
    hdr_o.cpl_mark       = 1'b1;
    hdr_o.is_uns_rd_size = desc_i.is_uns_rd_size;
    hdr_o.requester_id   = desc_i.requester_id;
    hdr_o.tag            = desc_i.tag;
    hdr_o.lower_addr     = lower_addr_q;
  end

  assign hdr_wr_o = seg.send;

endmodule

`default_nettype wire

//--- hw/txresp_pkg.sv
`default_nettype none

package txresp_pkg;

  // kind of completion the splitter is working on
  typedef enum logic [1:0] {
    CPL_FIRST = 2'd0,
    CPL_MAX   = 2'd1,
    CPL_LAST  = 2'd2
  } cpl_kind_t;

  // a header may be written while usedw is below this
  localparam int CMDFIFO_LIMIT = 8;

  // credit counters and their comparison window
  localparam int CREDIT_W      = 11;
  localparam int CREDIT_WINDOW = 1024;

endpackage

`default_nettype wire

//--- hw/txresp_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module txresp_req_decode (
  input  wire logic              AvlClk_i,
  input  wire logic              Rstn_i,
  input  wire logic              load_i,
  input  wire tlp_pkg::pndg_rd_t rd_word_i,
  output tlp_pkg::pndg_rd_t      desc_o,
  output logic [2:0]             first_mask_o,
  output logic [2:0]             last_mask_o,
  output logic [6:0]             lower_addr_o
);

  tlp_pkg::pndg_rd_t desc_q;
  logic [2:0]        first_mask_d;
  logic [2:0]        last_mask_d;
  logic [6:0]        lower_addr_d;

  // bytes disabled at the start of the first dword
  always_comb
  begin
    case (rd_word_i.fbe)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: first_mask_d = 3'd3;
      4'b0011, 4'b0110, 4'b1100:          first_mask_d = 3'd2;
      4'b0111, 4'b1110:                   first_mask_d = 3'd1;
      default:                            first_mask_d = 3'd0;
    endcase
  end

  // bytes disabled at the end of the last dword
  always_comb
  begin
    case (rd_word_i.lbe)
      4'b0111: last_mask_d = 3'd1;
      4'b0011: last_mask_d = 3'd2;
      4'b0001: last_mask_d = 3'd3;
      default: last_mask_d = 3'd0;
    endcase
  end

  // low address of the first enabled byte, flush stays dword aligned
  always_comb
  begin
    lower_addr_d = {rd_word_i.addr_dw, 2'b00};
    if (!rd_word_i.is_flush)
    begin
      if (rd_word_i.fbe[0])
        lower_addr_d[1:0] = 2'b00;
      else if (rd_word_i.fbe[1])
        lower_addr_d[1:0] = 2'b01;
      else if (rd_word_i.fbe[2])
        lower_addr_d[1:0] = 2'b10;
      else if (rd_word_i.fbe[3])
        lower_addr_d[1:0] = 2'b11;
    end
  end

  always_ff @(posedge AvlClk_i)
  begin
    if (load_i)
      desc_q <= rd_word_i;
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      first_mask_o <= '0;
      last_mask_o  <= '0;
      lower_addr_o <= '0;
    end
    else if (load_i)
    begin
      first_mask_o <= first_mask_d;
      last_mask_o  <= last_mask_d;
      lower_addr_o <= lower_addr_d;
    end
  end

  assign desc_o = desc_q;

endmodule

`default_nettype wire

//--- hw/txresp_seg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface txresp_seg_if;

  logic                      load;
  logic                      plan;
  logic [tlp_pkg::BCNT_W-1:0] seg_bytes;
  logic                      send;
  txresp_pkg::cpl_kind_t     kind;
  logic                      payload_ok;

  modport splitter (
    output load, plan, seg_bytes, send, kind,
    input  payload_ok
  );

  modport credit (
    input  load, plan, seg_bytes, send,
    output payload_ok
  );

  modport header (
    input load, send, kind, seg_bytes
  );

endinterface

`default_nettype wire

//--- hw/txresp_split_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module txresp_split_fsm (
  input  wire logic              AvlClk_i,
  input  wire logic              Rstn_i,
  input  wire logic              fifo_empty_i,
  input  wire logic [2:0]        dev_csr_mps_i,
  input  wire logic              cmd_busy_i,
  input  wire logic [3:0]        cmd_usedw_i,
  input  wire tlp_pkg::pndg_rd_t desc_i,
  output logic                   rd_req_o,
  output logic                   idle_o,
  txresp_seg_if.splitter         seg
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_FIFO,
    ST_LD_BCNT,
    ST_WAIT_DATA,
    ST_WAIT,
    ST_PIPE,
    ST_SEND,
    ST_DONE
  } state_t;

  state_t                     state_q;
  state_t                     state_d;
  logic                       first_q;
  logic [tlp_pkg::BCNT_W-1:0] curr_bcnt_q;
  logic [tlp_pkg::BCNT_W-1:0] seg_bytes_q;
  logic [tlp_pkg::BCNT_W-1:0] seg_bytes_d;
  txresp_pkg::cpl_kind_t      kind_q;
  txresp_pkg::cpl_kind_t      kind_d;
  logic [tlp_pkg::BCNT_W-1:0] max_payload;
  logic [tlp_pkg::BCNT_W-1:0] bytes_to_rcb;
  logic                       cmd_ok;
  logic                       no_data;

  assign cmd_ok  = !cmd_busy_i && (cmd_usedw_i < 4'(txresp_pkg::CMDFIFO_LIMIT));
  assign no_data = desc_i.is_flush || desc_i.is_uns_rd_size;

  // max payload field of the device control register
  assign max_payload = (dev_csr_mps_i == 3'd0) ? 13'd128 : 13'd256;

  assign bytes_to_rcb = tlp_pkg::BCNT_W'(tlp_pkg::RCB_BYTES)
                      - tlp_pkg::BCNT_W'({desc_i.addr_dw, 2'b00});

  // pick the next segment from what is still owed
  always_comb
  begin
    if (no_data)
    begin
      kind_d      = txresp_pkg::CPL_LAST;
      seg_bytes_d = curr_bcnt_q;
    end
    else if (first_q && (curr_bcnt_q > bytes_to_rcb))
    begin
      kind_d      = txresp_pkg::CPL_FIRST;
      seg_bytes_d = bytes_to_rcb;
    end
    else if (first_q || (curr_bcnt_q <= max_payload))
    begin
      kind_d      = txresp_pkg::CPL_LAST;
      seg_bytes_d = curr_bcnt_q;
    end
    else
    begin
      kind_d      = txresp_pkg::CPL_MAX;
      seg_bytes_d = max_payload;
    end
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (!fifo_empty_i)
          state_d = ST_RD_FIFO;
      ST_RD_FIFO:
        state_d = ST_LD_BCNT;
      ST_LD_BCNT:
        state_d = ST_WAIT_DATA;
      ST_WAIT_DATA:
        if (cmd_ok)
          state_d = no_data ? ST_SEND : ST_WAIT;
      ST_WAIT:
        state_d = ST_PIPE;
      ST_PIPE:
        if (seg.payload_ok && cmd_ok)
          state_d = ST_SEND;
      ST_SEND:
        if ((kind_q == txresp_pkg::CPL_LAST) || (curr_bcnt_q == seg_bytes_q))
          state_d = ST_DONE;
        else
          state_d = ST_WAIT_DATA;
      ST_DONE:
        state_d = ST_IDLE;
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state_q     <= ST_IDLE;
      first_q     <= 1'b0;
      curr_bcnt_q <= '0;
      seg_bytes_q <= '0;
      kind_q      <= txresp_pkg::CPL_FIRST;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == ST_LD_BCNT)
      begin
        first_q     <= 1'b1;
        curr_bcnt_q <= {desc_i.dwlen, 2'b00};
      end
      else if (state_q == ST_SEND)
      begin
        first_q     <= 1'b0;
        curr_bcnt_q <= curr_bcnt_q - seg_bytes_q;
      end
      // segment is frozen at the split decision
      if ((state_q == ST_WAIT_DATA) && cmd_ok)
      begin
        seg_bytes_q <= seg_bytes_d;
        kind_q      <= kind_d;
      end
    end
  end

  assign rd_req_o      = (state_q == ST_RD_FIFO);
  assign idle_o        = (state_q == ST_IDLE) && fifo_empty_i;
  assign seg.load      = (state_q == ST_LD_BCNT);
  assign seg.plan      = (state_q == ST_WAIT);
  assign seg.send      = (state_q == ST_SEND);
  assign seg.seg_bytes = seg_bytes_q;
  assign seg.kind      = kind_q;

endmodule

`default_nettype wire

//--- testbench/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rstn_o
);

  initial
  begin
    clk_o  = 1'b0;
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rstn_o <= 1'b1;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- testbench/tb_txresp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_txresp;

  localparam int NUM_REQS    = 80;
  localparam int WAIT_CYCLES = 2000;

  logic              clk;
  logic              rstn;
  logic              fifo_empty = 1'b1;
  tlp_pkg::pndg_rd_t rd_word    = '0;
  logic              data_valid = 1'b0;
  logic [3:0]        cmd_usedw  = 4'd0;
  logic              cmd_busy   = 1'b0;
  logic [31:0]       dev_csr    = 32'd0;
  logic              rd_req;
  logic [98:0]       cpl_hdr;
  logic              cpl_wr;
  logic [8:0]        cplbuf_addr;
  logic              resp_idle;

  integer seed         = 79;
  int     data_owed    = 0;
  int     beats_driven = 0;
  int     beats_seen   = 0;
  int     bytes_sent   = 0;

  tlp_pkg::cpl_hdr_t exp_hdr_q[$];
  int                exp_bytes_q[$];

  tb_clkgen u_clkgen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  tlp_txresp_cntrl u_tlp_txresp_cntrl (
    .AvlClk_i            (clk),
    .Rstn_i              (rstn),
    .RxPndgRdFifoEmpty_i (fifo_empty),
    .RxPndgRdFifoDato_i  (rd_word),
    .RxPndgRdFifoRdReq_o (rd_req),
    .TxReadDataValid_i   (data_valid),
    .CplReqHeader_o      (cpl_hdr),
    .CplReqWr_o          (cpl_wr),
    .CplRamWrAddr_o      (cplbuf_addr),
    .CmdFifoUsedw_i      (cmd_usedw),
    .CmdFifoBusy_i       (cmd_busy),
    .DevCsr_i            (dev_csr),
    .TxRespIdle_o        (resp_idle)
  );

  bind tlp_txresp_cntrl txresp_checker u_txresp_checker (
    .clk_i        (AvlClk_i),
    .rstn_i       (Rstn_i),
    .fifo_empty_i (RxPndgRdFifoEmpty_i),
    .rd_req_i     (RxPndgRdFifoRdReq_o),
    .cpl_wr_i     (CplReqWr_o),
    .cmd_busy_i   (CmdFifoBusy_i)
  );

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("Checks failed");
      $fatal(1, "simulation stopped");
    end
  endtask

  // disabled bytes of a contiguous byte enable
  function automatic int disabled_bytes(input logic [3:0] be);
    int n;
    int i;
    n = 4;
    for (i = 0; i < 4; i++)
      if (be[i])
        n--;
    return (be == 4'd0) ? 0 : n;
  endfunction

  function automatic int first_offset(input logic [3:0] be);
    int off;
    int i;
    off = 0;
    for (i = 3; i >= 0; i--)
      if (be[i])
        off = i;
    return off;
  endfunction

  // reference split of one request into completion headers
  task automatic queue_expected(input tlp_pkg::pndg_rd_t d, input int mps);
    tlp_pkg::cpl_hdr_t h;
    int                addr;
    int                owed;
    int                seg;
    int                fmask;
    int                lmask;
    logic              first;
    h                = '0;
    h.attr           = d.attr;
    h.tc             = d.tc;
    h.is_flush       = d.is_flush;
    h.cpl_mark       = 1'b1;
    h.is_uns_rd_size = d.is_uns_rd_size;
    h.requester_id   = d.requester_id;
    h.tag            = d.tag;
    addr  = int'(d.addr_dw) * 4;
    owed  = int'(d.dwlen) * 4;
    fmask = disabled_bytes(d.fbe);
    lmask = disabled_bytes(d.lbe);
    if (d.is_flush)
    begin
      h.dw_len       = 9'd1;
      h.remain_bytes = 12'd1;
      h.lower_addr   = 7'(addr);
      exp_hdr_q.push_back(h);
      exp_bytes_q.push_back(0);
    end
    else if (d.is_uns_rd_size)
    begin
      h.dw_len       = 9'd0;
      h.remain_bytes = 12'(owed - fmask - lmask);
      h.lower_addr   = 7'(addr + first_offset(d.fbe));
      exp_hdr_q.push_back(h);
      exp_bytes_q.push_back(0);
    end
    else
    begin
      first = 1'b1;
      while (owed > 0)
      begin
        // first completion stops at the RCB, the rest at max payload
        if (first)
          seg = (owed < 128 - addr) ? owed : 128 - addr;
        else
          seg = (owed < mps) ? owed : mps;
        h.dw_len       = 9'(seg / 4);
        h.remain_bytes = 12'(owed - lmask - (first ? fmask : 0));
        h.lower_addr   = first ? 7'(addr + first_offset(d.fbe)) : 7'd0;
        exp_hdr_q.push_back(h);
        exp_bytes_q.push_back(seg);
        owed  = owed - seg;
        first = 1'b0;
      end
    end
  endtask

  task automatic check_header();
    tlp_pkg::cpl_hdr_t got;
    tlp_pkg::cpl_hdr_t exp;
    got = cpl_hdr;
    if (exp_hdr_q.size() == 0)
      stop_run("completion header written while none was expected");
    else
    begin
      exp        = exp_hdr_q.pop_front();
      bytes_sent = bytes_sent + exp_bytes_q.pop_front();
      check_value("CplReqHeader_o.dw_len", got.dw_len, exp.dw_len);
      check_value("CplReqHeader_o.remain_bytes", got.remain_bytes, exp.remain_bytes);
      check_value("CplReqHeader_o.tag", got.tag, exp.tag);
      check_value("CplReqHeader_o.requester_id", got.requester_id, exp.requester_id);
      check_value("CplReqHeader_o.attr", got.attr, exp.attr);
      check_value("CplReqHeader_o.tc", got.tc, exp.tc);
      check_value("CplReqHeader_o.lower_addr", got.lower_addr, exp.lower_addr);
      check_value("CplReqHeader_o.is_flush", got.is_flush, exp.is_flush);
      check_value("CplReqHeader_o.is_uns_rd_size", got.is_uns_rd_size, exp.is_uns_rd_size);
      check_value("CplReqHeader_o.cpl_mark", got.cpl_mark, exp.cpl_mark);
      check_value("returned bytes cover sent bytes", beats_seen * 16 >= bytes_sent, 1);
    end
  endtask

  task automatic pass_reset();
    int cycles;
    cycles = 0;
    while (!rstn && (cycles < 20))
    begin
      @(negedge clk);
      cycles++;
    end
    if (!rstn)
      stop_run("reset was never released");
  endtask

  task automatic wait_rd_req();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!rd_req && (cycles < WAIT_CYCLES))
    begin
      @(negedge clk);
      cycles++;
    end
    if (!rd_req)
      stop_run("timeout waiting for the pending-read FIFO read request");
  endtask

  task automatic drain_headers();
    int cycles;
    cycles = 0;
    while ((exp_hdr_q.size() != 0) && (cycles < WAIT_CYCLES))
    begin
      @(negedge clk);
      cycles++;
    end
    if (exp_hdr_q.size() != 0)
      stop_run("timeout waiting for the expected completion headers");
  endtask

  task automatic reach_idle();
    int cycles;
    cycles = 0;
    while (!resp_idle && (cycles < WAIT_CYCLES))
    begin
      @(negedge clk);
      cycles++;
    end
    if (!resp_idle)
      stop_run("timeout waiting for the idle indication");
  endtask

  // command FIFO state and returned read data, one draw per cycle
  always @(posedge clk)
  begin
    if (rstn)
    begin
      cmd_busy  <= (($random(seed) & 3) == 0);
      cmd_usedw <= 4'($random(seed));
      if ((beats_driven * 16 < data_owed) && (($random(seed) & 1) == 1))
      begin
        data_valid   <= 1'b1;
        beats_driven <= beats_driven + 1;
      end
      else
        data_valid <= 1'b0;
    end
  end

  // outputs are sampled mid-cycle
  always @(negedge clk)
  begin
    if (rstn)
    begin
      if (u_tlp_txresp_cntrl.u_txresp_checker.fail_count != 0)
        stop_run("a bound assertion on the DUT strobes failed");
      check_value("CplRamWrAddr_o", cplbuf_addr, beats_seen % 512);
      if (cpl_wr)
        check_header();
      if (data_valid)
        beats_seen = beats_seen + 1;
    end
  end

  initial
  begin
    tlp_pkg::pndg_rd_t d;
    logic [31:0]       csr;
    int                kind;
    int                start;
    int                len;
    int                mps;
    int                n;
    pass_reset();
    check_value("RxPndgRdFifoRdReq_o", rd_req, 0);
    check_value("CplReqWr_o", cpl_wr, 0);
    check_value("TxRespIdle_o", resp_idle, 1);
    for (n = 0; n < NUM_REQS; n++)
    begin
      d              = '0;
      kind           = $random(seed) & 7;
      d.tag          = 8'($random(seed));
      d.requester_id = 16'($random(seed));
      d.attr         = 2'($random(seed));
      d.tc           = 3'($random(seed));
      d.addr_dw      = 5'($random(seed));
      d.dwlen        = 11'(($random(seed) & 63) + 1);
      if (kind == 0)
      begin
        d.is_flush = 1'b1;
        d.dwlen    = 11'd1;
      end
      else
      begin
        d.is_uns_rd_size = (kind == 1);
        if (d.dwlen == 11'd1)
        begin
          // any contiguous run inside the single dword
          start = $unsigned($random(seed)) % 4;
          len   = 1 + $unsigned($random(seed)) % (4 - start);
          d.fbe = 4'(((1 << len) - 1) << start);
        end
        else
        begin
          d.fbe = 4'(4'hf << ($random(seed) & 3));
          d.lbe = 4'(4'hf >> ($random(seed) & 3));
        end
      end
      csr = $random(seed);
      if (($random(seed) & 1) == 1)
        csr[7:5] = 3'd0;
      mps = (csr[7:5] == 3'd0) ? 128 : 256;
      queue_expected(d, mps);
      @(posedge clk);
      rd_word    <= d;
      dev_csr    <= csr;
      fifo_empty <= 1'b0;
      if (!d.is_flush && !d.is_uns_rd_size)
        data_owed <= data_owed + int'(d.dwlen) * 4;
      wait_rd_req();
      @(posedge clk);
      fifo_empty <= 1'b1;
      drain_headers();
      reach_idle();
    end
    repeat (4) @(negedge clk);
    if (u_tlp_txresp_cntrl.u_txresp_checker.fail_count != 0)
    begin
      $display("bound assertions failed %0d times",
               u_tlp_txresp_cntrl.u_txresp_checker.fail_count);
      $display("Checks failed");
      $fatal(1, "simulation stopped");
    end
    else
    begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- testbench/txresp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module txresp_checker (
  input wire logic clk_i,
  input wire logic rstn_i,
  input wire logic fifo_empty_i,
  input wire logic rd_req_i,
  input wire logic cpl_wr_i,
  input wire logic cmd_busy_i
);

  int fail_count = 0;

  // the show-ahead FIFO is only read while it holds a word
  a_rd_req_not_empty: assert property (
    @(posedge clk_i) disable iff (!rstn_i) rd_req_i |-> !fifo_empty_i)
  else
  begin
    fail_count++;
    $error("read request while the pending-read FIFO is empty");
  end

  a_rd_req_pulse: assert property (
    @(posedge clk_i) disable iff (!rstn_i) rd_req_i |=> !rd_req_i)
  else
  begin
    fail_count++;
    $error("read request held longer than one cycle");
  end

  a_cpl_wr_spaced: assert property (
    @(posedge clk_i) disable iff (!rstn_i) cpl_wr_i |=> !cpl_wr_i)
  else
  begin
    fail_count++;
    $error("header write strobes back to back");
  end

  // a header is only issued after a cycle with the command FIFO free
  a_cpl_wr_after_busy: assert property (
    @(posedge clk_i) disable iff (!rstn_i) cmd_busy_i |=> !cpl_wr_i)
  else
  begin
    fail_count++;
    $error("header written right after a busy cycle");
  end

endmodule

`default_nettype wire

//--- tlp_txresp_cntrl.f
hw/tlp_pkg.sv
hw/txresp_pkg.sv
hw/txresp_seg_if.sv
hw/txresp_req_decode.sv
hw/txresp_split_fsm.sv
hw/txresp_credit_tracker.sv
hw/txresp_hdr_build.sv
hw/tlp_txresp_cntrl.sv
testbench/tb_clkgen.sv
testbench/txresp_checker.sv
testbench/tb_txresp.sv
